/* axi_pkg.sv */
package axi_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;
  localparam int resp_w = 2;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;
  typedef logic [resp_w-1:0] resp_t;

  // slverr marks a request the subordinate refuses, decerr an unmapped address.
  localparam resp_t resp_okay   = 2'd0;
  localparam resp_t resp_slverr = 2'd2;
  localparam resp_t resp_decerr = 2'd3;

endpackage

/* soc_map_pkg.sv */
package soc_map_pkg;

  // sram sits in the window whose top five address bits are 10000.
  localparam logic [4:0] sram_base_hi = 5'b10000;
  localparam int sram_depth = 1024;
  localparam int sram_idx_w = $clog2(sram_depth);

  localparam axi_pkg::addr_t clint_mtime_lo = 32'ha000_0048;
  localparam axi_pkg::addr_t clint_mtime_hi = 32'ha000_004c;
  localparam axi_pkg::addr_t uart_tx_addr   = 32'ha000_03f8;

  typedef enum logic [2:0] {
    tgt_none,
    tgt_sram,
    tgt_clint,
    tgt_uart,
    tgt_err
  } target_e;

endpackage

/* axi_xbar.sv */
module axi_xbar
  import axi_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  // manager side
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  // sram
  output addr_t sram_araddr,
  output logic  sram_arvalid,
  input  logic  sram_arready,
  input  data_t sram_rdata,
  input  resp_t sram_rresp,
  input  logic  sram_rvalid,
  output logic  sram_rready,
  output addr_t sram_awaddr,
  output logic  sram_awvalid,
  input  logic  sram_awready,
  output data_t sram_wdata,
  output strb_t sram_wstrb,
  output logic  sram_wvalid,
  input  logic  sram_wready,
  input  resp_t sram_bresp,
  input  logic  sram_bvalid,
  output logic  sram_bready,
  // clint, read only
  output addr_t clint_araddr,
  output logic  clint_arvalid,
  input  logic  clint_arready,
  input  data_t clint_rdata,
  input  resp_t clint_rresp,
  input  logic  clint_rvalid,
  output logic  clint_rready,
  // uart, write only
  output addr_t uart_awaddr,
  output logic  uart_awvalid,
  input  logic  uart_awready,
  output data_t uart_wdata,
  output strb_t uart_wstrb,
  output logic  uart_wvalid,
  input  logic  uart_wready,
  input  resp_t uart_bresp,
  input  logic  uart_bvalid,
  output logic  uart_bready
);

  target_e ar_dec;
  target_e aw_dec;
  target_e rd_tgt;
  target_e wr_tgt;
  logic    read_busy;
  logic    write_busy;
  logic    err_bvalid;

  always_comb begin
    if (araddr[31:27] == sram_base_hi) begin
      ar_dec = tgt_sram;
    end else if (araddr == clint_mtime_lo || araddr == clint_mtime_hi) begin
      ar_dec = tgt_clint;
    end else begin
      ar_dec = tgt_err;
    end
  end

  always_comb begin
    if (awaddr[31:27] == sram_base_hi) begin
      aw_dec = tgt_sram;
    end else if (awaddr == uart_tx_addr) begin
      aw_dec = tgt_uart;
    end else begin
      aw_dec = tgt_err;
    end
  end

  assign read_busy  = (rd_tgt != tgt_none);
  assign write_busy = (wr_tgt != tgt_none);

  assign sram_araddr   = araddr;
  assign clint_araddr  = araddr;
  assign sram_arvalid  = arvalid && !read_busy && (ar_dec == tgt_sram);
  assign clint_arvalid = arvalid && !read_busy && (ar_dec == tgt_clint);

  // unmapped reads are accepted here and answered one cycle later.
  always_comb begin
    case (ar_dec)
      tgt_sram:  arready = !read_busy && sram_arready;
      tgt_clint: arready = !read_busy && clint_arready;
      default:   arready = !read_busy;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_tgt <= tgt_none;
    end else if (arvalid && arready) begin
      rd_tgt <= ar_dec;
    end else if (rvalid && rready) begin
      rd_tgt <= tgt_none;
    end
  end

  assign sram_rready  = rready && (rd_tgt == tgt_sram);
  assign clint_rready = rready && (rd_tgt == tgt_clint);

  always_comb begin
    case (rd_tgt)
      tgt_sram: begin
        rdata  = sram_rdata;
        rresp  = sram_rresp;
        rvalid = sram_rvalid;
      end
      tgt_clint: begin
        rdata  = clint_rdata;
        rresp  = clint_rresp;
        rvalid = clint_rvalid;
      end
      tgt_err: begin
        rdata  = '0;
        rresp  = resp_decerr;
        rvalid = 1'b1;
      end
      default: begin
        rdata  = '0;
        rresp  = resp_okay;
        rvalid = 1'b0;
      end
    endcase
  end

  assign sram_awaddr  = awaddr;
  assign uart_awaddr  = awaddr;
  assign sram_awvalid = awvalid && !write_busy && (aw_dec == tgt_sram);
  assign uart_awvalid = awvalid && !write_busy && (aw_dec == tgt_uart);

  always_comb begin
    case (aw_dec)
      tgt_sram: awready = !write_busy && sram_awready;
      tgt_uart: awready = !write_busy && uart_awready;
      default:  awready = !write_busy;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_tgt <= tgt_none;
    end else if (awvalid && awready) begin
      wr_tgt <= aw_dec;
    end else if (bvalid && bready) begin
      wr_tgt <= tgt_none;
    end
  end

  // the error responder swallows the write data, then raises bvalid.
  always_ff @(posedge clk) begin
    if (rstn) begin
      err_bvalid <= 1'b0;
    end else if (wr_tgt == tgt_err && wvalid && wready) begin
      err_bvalid <= 1'b1;
    end else if (bvalid && bready) begin
      err_bvalid <= 1'b0;
    end
  end

  assign sram_wdata  = wdata;
  assign sram_wstrb  = wstrb;
  assign uart_wdata  = wdata;
  assign uart_wstrb  = wstrb;
  assign sram_wvalid = wvalid && (wr_tgt == tgt_sram);
  assign uart_wvalid = wvalid && (wr_tgt == tgt_uart);
  assign sram_bready = bready && (wr_tgt == tgt_sram);
  assign uart_bready = bready && (wr_tgt == tgt_uart);

  always_comb begin
    case (wr_tgt)
      tgt_sram: begin
        wready = sram_wready;
        bresp  = sram_bresp;
        bvalid = sram_bvalid;
      end
      tgt_uart: begin
        wready = uart_wready;
        bresp  = uart_bresp;
        bvalid = uart_bvalid;
      end
      tgt_err: begin
        wready = !err_bvalid;
        bresp  = resp_decerr;
        bvalid = err_bvalid;
      end
      default: begin
        wready = 1'b0;
        bresp  = resp_okay;
        bvalid = 1'b0;
      end
    endcase
  end

  // a stalled response must keep its route until the manager takes it.
  a_rd_tgt_hold: assert property (@(posedge clk) disable iff (rstn)
    rvalid && !rready |=> $stable(rd_tgt));
  a_wr_tgt_hold: assert property (@(posedge clk) disable iff (rstn)
    bvalid && !bready |=> $stable(wr_tgt));
  a_ar_onehot: assert property (@(posedge clk) disable iff (rstn)
    $onehot0({sram_arvalid, clint_arvalid}));

endmodule

/* sram_slave.sv */
module sram_slave
  import axi_pkg::*;
  import soc_map_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready,
  input  addr_t awaddr,
  input  logic  awvalid,
  output logic  awready,
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready
);

  data_t                 mem [sram_depth];
  logic [sram_idx_w-1:0] w_idx;

  assign arready = !rvalid;
  assign rresp   = resp_okay;
  assign awready = !wready && !bvalid;
  assign bresp   = resp_okay;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // word index from bits 11:2, so higher address bits alias.
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rdata <= mem[araddr[sram_idx_w+1:2]];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      wready <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        wready <= 1'b1;
      end
      if (wvalid && wready) begin
        wready <= 1'b0;
        bvalid <= 1'b1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      w_idx <= awaddr[sram_idx_w+1:2];
    end
    if (wvalid && wready) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (wstrb[i]) begin
          mem[w_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rstn)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* clint_slave.sv */
module clint_slave
  import axi_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  addr_t araddr,
  input  logic  arvalid,
  output logic  arready,
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready
);

  logic [63:0] mtime;

  assign arready = !rvalid;
  assign rresp   = resp_okay;

  always_ff @(posedge clk) begin
    if (rstn) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // only the two mtime words reach this block, bit 2 tells them apart.
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      rdata <= araddr[2] ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

/* uart_tx_slave.sv */
module uart_tx_slave
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  addr_t      awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  data_t      wdata,
  input  strb_t      wstrb,
  input  logic       wvalid,
  output logic       wready,
  output resp_t      bresp,
  output logic       bvalid,
  input  logic       bready,
  output logic [7:0] uart_byte,
  output logic       uart_strobe
);

  assign awready = !wready && !bvalid;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      uart_strobe <= 1'b0;
    end else begin
      uart_strobe <= 1'b0;
      if (awvalid && awready) begin
        wready <= 1'b1;
      end
      if (wvalid && wready) begin
        wready      <= 1'b0;
        bvalid      <= 1'b1;
        uart_strobe <= wstrb[0];
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // a write without the low byte lane has nothing to send.
  always_ff @(posedge clk) begin
    if (wvalid && wready) begin
      bresp <= wstrb[0] ? resp_okay : resp_slverr;
      if (wstrb[0]) begin
        uart_byte <= wdata[7:0];
      end
    end
  end

  a_strobe_pulse: assert property (@(posedge clk) disable iff (rstn)
    uart_strobe |=> !uart_strobe);
  a_aw_aligned: assert property (@(posedge clk) disable iff (rstn)
    awvalid && awready |-> awaddr[1:0] == 2'b00);

endmodule

/* soc_bus_top.sv */
module soc_bus_top
  import axi_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  addr_t      araddr,
  input  logic       arvalid,
  output logic       arready,
  output data_t      rdata,
  output resp_t      rresp,
  output logic       rvalid,
  input  logic       rready,
  input  addr_t      awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  data_t      wdata,
  input  strb_t      wstrb,
  input  logic       wvalid,
  output logic       wready,
  output resp_t      bresp,
  output logic       bvalid,
  input  logic       bready,
  output logic [7:0] uart_byte,
  output logic       uart_strobe
);

  addr_t sram_araddr;
  addr_t sram_awaddr;
  addr_t clint_araddr;
  addr_t uart_awaddr;
  data_t sram_rdata;
  data_t sram_wdata;
  data_t clint_rdata;
  data_t uart_wdata;
  strb_t sram_wstrb;
  strb_t uart_wstrb;
  resp_t sram_rresp;
  resp_t sram_bresp;
  resp_t clint_rresp;
  resp_t uart_bresp;
  logic  sram_arvalid, sram_arready, sram_rvalid, sram_rready;
  logic  sram_awvalid, sram_awready, sram_wvalid, sram_wready;
  logic  sram_bvalid, sram_bready;
  logic  clint_arvalid, clint_arready, clint_rvalid, clint_rready;
  logic  uart_awvalid, uart_awready, uart_wvalid, uart_wready;
  logic  uart_bvalid, uart_bready;

  axi_xbar xbar0 (.*);

  sram_slave sram0 (
    .clk, .rstn,
    .araddr(sram_araddr), .arvalid(sram_arvalid), .arready(sram_arready),
    .rdata(sram_rdata), .rresp(sram_rresp), .rvalid(sram_rvalid), .rready(sram_rready),
    .awaddr(sram_awaddr), .awvalid(sram_awvalid), .awready(sram_awready),
    .wdata(sram_wdata), .wstrb(sram_wstrb), .wvalid(sram_wvalid), .wready(sram_wready),
    .bresp(sram_bresp), .bvalid(sram_bvalid), .bready(sram_bready)
  );

  clint_slave clint0 (
    .clk, .rstn,
    .araddr(clint_araddr), .arvalid(clint_arvalid), .arready(clint_arready),
    .rdata(clint_rdata), .rresp(clint_rresp), .rvalid(clint_rvalid), .rready(clint_rready)
  );

  uart_tx_slave uart0 (
    .clk, .rstn,
    .awaddr(uart_awaddr), .awvalid(uart_awvalid), .awready(uart_awready),
    .wdata(uart_wdata), .wstrb(uart_wstrb), .wvalid(uart_wvalid), .wready(uart_wready),
    .bresp(uart_bresp), .bvalid(uart_bvalid), .bready(uart_bready),
    .uart_byte, .uart_strobe
  );

endmodule

/* tb_soc_bus.sv */
module tb_soc_bus
  import axi_pkg::*;
();

  localparam int ch_ar = 0;
  localparam int ch_r  = 1;
  localparam int ch_aw = 2;
  localparam int ch_w  = 3;
  localparam int ch_b  = 4;
  localparam int timeout_cycles = 50;
  localparam int golden_words = 256;

  logic       clk;
  logic       rstn;
  addr_t      araddr;
  logic       arvalid;
  logic       arready;
  data_t      rdata;
  resp_t      rresp;
  logic       rvalid;
  logic       rready;
  addr_t      awaddr;
  logic       awvalid;
  logic       awready;
  data_t      wdata;
  strb_t      wstrb;
  logic       wvalid;
  logic       wready;
  resp_t      bresp;
  logic       bvalid;
  logic       bready;
  logic [7:0] uart_byte;
  logic       uart_strobe;

  logic [31:0] golden [golden_words];
  logic [31:0] lfsr_state;
  logic [7:0]  last_byte;
  int          pulse_cnt;
  int          err_cnt;
  bit          timed_out;

  soc_bus_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // uart pulses are counted mid-cycle, where the strobe is stable.
  always @(negedge clk) begin
    if (uart_strobe) begin
      pulse_cnt = pulse_cnt + 1;
      last_byte = uart_byte;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic pick_delay(output int d);
    lfsr_state = lfsr_next(lfsr_state);
    d = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    d = 2 * d + lfsr_state[0];
  endtask

  function automatic logic chan_sig(input int ch);
    case (ch)
      ch_ar:   return arready;
      ch_r:    return rvalid;
      ch_aw:   return awready;
      ch_w:    return wready;
      default: return bvalid;
    endcase
  endfunction

  function automatic string chan_name(input int ch);
    case (ch)
      ch_ar:   return "AR";
      ch_r:    return "R";
      ch_aw:   return "AW";
      ch_w:    return "W";
      default: return "B";
    endcase
  endfunction

  task automatic check_val(input string tname, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", tname, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_cond(input string tname, input bit ok, input string msg);
    assert (ok) else begin
      $display("[ERROR] %s: %s", tname, msg);
      err_cnt++;
    end
  endtask

  task automatic wait_for(input int ch, input string tname);
    int n;
    n = 0;
    if (!timed_out) begin
      @(negedge clk);
      while (!chan_sig(ch) && n < timeout_cycles) begin
        @(negedge clk);
        n++;
      end
      assert (n < timeout_cycles) else begin
        $display("%s: the %s channel stalled for %0d cycles", tname, chan_name(ch), n);
        err_cnt++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic do_read(input string tname, input addr_t addr,
                         output data_t data, output resp_t resp);
    int d;
    @(posedge clk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    wait_for(ch_ar, tname);
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    pick_delay(d);
    wait_for(ch_r, tname);
    data = rdata;
    resp = rresp;
    repeat (d) begin
      @(negedge clk);
      check_cond(tname, rvalid && rdata === data && rresp === resp,
                 "read response changed while rready was low");
      check_cond(tname, !arready, "arready was high while a read response was pending");
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic do_write(input string tname, input addr_t addr, input data_t data,
                          input strb_t strb, output resp_t resp);
    int d;
    @(posedge clk);
    #1;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    wait_for(ch_aw, tname);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wait_for(ch_w, tname);
    @(posedge clk);
    #1;
    wvalid = 1'b0;
    pick_delay(d);
    wait_for(ch_b, tname);
    resp = bresp;
    repeat (d) begin
      @(negedge clk);
      check_cond(tname, bvalid && bresp === resp,
                 "write response changed while bready was low");
      check_cond(tname, !awready, "awready was high while a write response was pending");
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  initial begin
    int          idx;
    int          errs_before;
    int          n_pass;
    int          n_fail;
    int          exp_pulses;
    logic [31:0] op;
    logic [31:0] ed;
    logic [31:0] er;
    data_t       got_data;
    resp_t       got_resp;
    data_t       prev_time;
    bit          have_prev;
    string       tname;
    rstn       = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    lfsr_state = 32'h8130;
    pulse_cnt  = 0;
    last_byte  = '0;
    err_cnt    = 0;
    timed_out  = 1'b0;
    have_prev  = 1'b0;
    prev_time  = '0;
    n_pass     = 0;
    n_fail     = 0;
    $readmemh("bus_golden.txt", golden);

    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b0;
    @(negedge clk);
    tname = "reset state";
    errs_before = err_cnt;
    check_cond(tname, rvalid === 1'b0, "rvalid was not low after reset");
    check_cond(tname, bvalid === 1'b0, "bvalid was not low after reset");
    check_cond(tname, wready === 1'b0, "wready was not low after reset");
    check_cond(tname, uart_strobe === 1'b0, "uart_strobe was not low after reset");
    check_cond(tname, arready === 1'b1 && awready === 1'b1,
               "arready or awready was not high after reset");
    if (err_cnt == errs_before) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("%s: %s", tname, (err_cnt == errs_before) ? "ok" : "failed");

    // each golden line holds op, addr, data, strb, expected data, expected resp.
    idx = 0;
    while (!timed_out && 6 * idx + 5 < golden_words && golden[6 * idx] != 32'd0) begin
      op = golden[6 * idx];
      ed = golden[6 * idx + 4];
      er = golden[6 * idx + 5];
      tname = $sformatf("test %0d op %0d addr %h", idx, op, golden[6 * idx + 1]);
      errs_before = err_cnt;
      pulse_cnt = 0;
      if (op == 32'd1 || op == 32'd3) begin
        do_write(tname, golden[6 * idx + 1], golden[6 * idx + 2],
                 golden[6 * idx + 3][3:0], got_resp);
        check_val(tname, "bresp", er, {30'b0, got_resp});
        exp_pulses = (op == 32'd3 && er == 32'd0) ? 1 : 0;
        check_val(tname, "uart_strobe pulses", exp_pulses, pulse_cnt);
        if (exp_pulses == 1) begin
          check_val(tname, "uart_byte", ed[7:0], {24'b0, last_byte});
        end
      end else if (op == 32'd2 || op == 32'd4) begin
        do_read(tname, golden[6 * idx + 1], got_data, got_resp);
        check_val(tname, "rresp", er, {30'b0, got_resp});
        if (op == 32'd2) begin
          check_val(tname, "rdata", ed, got_data);
        end else begin
          if (have_prev) begin
            check_cond(tname, got_data > prev_time, "mtime did not increase between reads");
          end
          prev_time = got_data;
          have_prev = 1'b1;
        end
      end else begin
        check_cond(tname, 1'b0, "the golden file holds an unknown operation code");
      end
      if (err_cnt == errs_before) begin
        n_pass++;
      end else begin
        n_fail++;
      end
      $display("%s: %s", tname, (err_cnt == errs_before) ? "ok" : "failed");
      idx++;
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* bus_golden.txt */
// columns: op addr data strb exp_data exp_resp, all hex
// op 1 write, 2 read, 3 uart write with exp_data as the byte, 4 mtime_lo read, 0 end
1 80000000 11223344 f 00000000 0
1 80000004 a5a5a5a5 f 00000000 0
1 800003fc deadbeef f 00000000 0
1 80000ffc 0badf00d f 00000000 0
2 80000000 00000000 0 11223344 0
2 80000004 00000000 0 a5a5a5a5 0
2 800003fc 00000000 0 deadbeef 0
2 80000ffc 00000000 0 0badf00d 0
1 80000004 00ff0000 4 00000000 0
1 80000004 0000003c 1 00000000 0
2 80000004 00000000 0 a5ffa53c 0
2 80001004 00000000 0 a5ffa53c 0
2 84000000 00000000 0 11223344 0
1 80002000 cafe0000 c 00000000 0
2 80000000 00000000 0 cafe3344 0
3 a00003f8 00000041 1 00000041 0
3 a00003f8 0000ff5a f 0000005a 0
3 a00003f8 00004200 2 00000000 2
4 a0000048 00000000 0 00000000 0
4 a0000048 00000000 0 00000000 0
2 a000004c 00000000 0 00000000 0
2 a00003f8 00000000 0 00000000 3
1 a0000048 12345678 f 00000000 3
2 00001000 00000000 0 00000000 3
1 90000000 ffffffff f 00000000 3
2 a0000050 00000000 0 00000000 3
2 80000ffc 00000000 0 0badf00d 0
0 00000000 00000000 0 00000000 0

/* vlog.f */
axi_pkg.sv
soc_map_pkg.sv
axi_xbar.sv
sram_slave.sv
clint_slave.sv
uart_tx_slave.sv
soc_bus_top.sv
tb_soc_bus.sv
